//--- dv/i2c_host_regs_props.sv
// ====================
// Wishbone ack properties
// Bound to the I2C host register block
// ====================
`timescale 1ns/1ps

module i2c_host_regs_props (
    input logic clk,
    input logic rst,
    input logic wbs_cyc_i,
    input logic wbs_stb_i,
    input logic wbs_ack_o
);
    // Never two acks back to back
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_o |=> !wbs_ack_o)
        else $error("Wishbone ack held high for two cycles");

    // Ack must answer a request from the cycle before
    ack_after_request: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i))
        else $error("Wishbone ack without a preceding request");

    // Quiet bus during reset
    ack_low_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !wbs_ack_o)
        else $error("Wishbone ack high during reset");

endmodule

//--- dv/i2c_host_regs_tb.sv
// ====================
// I2C host register block testbench
// Table of Wishbone accesses and engine actions, engine modelled here
// ====================
`timescale 1ns/1ps

module i2c_host_regs_tb;
    import i2c_host_pkg::*;

    // Row kinds
    localparam int K_WRITE = 0;
    localparam int K_READ  = 1;
    localparam int K_PUSH  = 2;
    localparam int K_DRAIN = 3;
    localparam int K_LEVEL = 4;
    localparam int ACK_LIMIT = 16;
    localparam int CYCLES_PER_ROW = 64;

    // Status register bits
    localparam logic [15:0] S_CMD_E   = 16'h0100;
    localparam logic [15:0] S_CMD_F   = 16'h0200;
    localparam logic [15:0] S_CMD_OVF = 16'h0400;
    localparam logic [15:0] S_WR_E    = 16'h0800;
    localparam logic [15:0] S_WR_F    = 16'h1000;
    localparam logic [15:0] S_WR_OVF  = 16'h2000;
    localparam logic [15:0] S_RD_E    = 16'h4000;
    localparam logic [15:0] S_IDLE    = S_CMD_E | S_WR_E | S_RD_E;

    logic clk, rst;
    reg_addr_t wb_adr;
    host_word_t wb_dat_w, wb_dat_r;
    byte_sel_t wb_sel;
    logic wb_we, wb_stb, wb_ack, wb_cyc;
    cmd_word_t cmd;
    logic cmd_valid, cmd_ready;
    i2c_byte_t wr_data, rd_data;
    logic wr_last, wr_valid, wr_ready, rd_last, rd_valid, rd_ready;
    logic busy, bus_control, bus_active, missed_ack;
    prescale_t prescale;

    // Stimulus table
    string       row_name[$];
    int          row_kind[$];
    logic [2:0]  row_addr[$];
    logic [1:0]  row_sel[$];
    logic [15:0] row_data[$];
    logic [15:0] row_exp[$];
    logic [15:0] lfsr_state;
    logic        rows_ready;

    tb_clock_gen u_clk (.clk_o(clk));

    i2c_host_regs_top UUT (
        .clk(clk), .rst(rst),
        .wbs_adr_i(wb_adr), .wbs_dat_i(wb_dat_w), .wbs_dat_o(wb_dat_r),
        .wbs_we_i(wb_we), .wbs_sel_i(wb_sel), .wbs_stb_i(wb_stb),
        .wbs_ack_o(wb_ack), .wbs_cyc_i(wb_cyc),
        .cmd_o(cmd), .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
        .wr_data_o(wr_data), .wr_last_o(wr_last), .wr_valid_o(wr_valid),
        .wr_ready_i(wr_ready),
        .rd_data_i(rd_data), .rd_last_i(rd_last), .rd_valid_i(rd_valid),
        .rd_ready_o(rd_ready),
        .busy_i(busy), .bus_control_i(bus_control), .bus_active_i(bus_active),
        .missed_ack_i(missed_ack), .prescale_o(prescale)
    );

    bind i2c_host_regs_top i2c_host_regs_props u_props (
        .clk(clk), .rst(rst), .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i),
        .wbs_ack_o(wbs_ack_o)
    );

    // Galois LFSR, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    // Flags run start, read, write, write_multiple, stop from high to low
    function automatic logic [15:0] cmd_reg_word(input logic [6:0] addr,
                                                 input logic [4:0] flags);
        return {3'b0, flags[0], flags[1], flags[2], flags[3], flags[4], 1'b0, addr};
    endfunction

    task automatic add_row(input string name, input int kind, input logic [2:0] addr,
                           input logic [1:0] sel, input logic [15:0] data,
                           input logic [15:0] exp);
        row_name.push_back(name);
        row_kind.push_back(kind);
        row_addr.push_back(addr);
        row_sel.push_back(sel);
        row_data.push_back(data);
        row_exp.push_back(exp);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    // One Wishbone access, held until ack
    task automatic wb_access(input string name, input logic we, input logic [2:0] addr,
                             input logic [1:0] sel, input logic [15:0] data,
                             output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = addr;
        wb_sel = sel;
        wb_dat_w = data;
        @(negedge clk);
        while (wb_ack !== 1'b1) begin
            if (waited == ACK_LIMIT) begin
                abort_run($sformatf("%s got no Wishbone ack in %0d cycles", name, ACK_LIMIT));
            end
            waited++;
            @(negedge clk);
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        // Ack must already be gone
        @(negedge clk);
        check_value({name, " ack width"}, 16'd0, {15'd0, wb_ack});
    endtask

    // Engine takes one entry; which 0 is commands, 1 is write data
    task automatic drain_stream(input string name, input logic which,
                                input logic [15:0] exp);
        logic [15:0] got;
        logic valid;
        @(negedge clk);
        got = which ? {6'b0, wr_valid, wr_data, wr_last} : {3'b0, cmd_valid, cmd};
        valid = which ? wr_valid : cmd_valid;
        // Empty queue head holds stale data
        if (!(which ? exp[9] : exp[12])) begin
            check_value(name, 16'd0, {15'd0, valid});
        end else begin
            check_value(name, exp, got);
            cmd_ready = !which;
            wr_ready = which;
            @(negedge clk);
            cmd_ready = 1'b0;
            wr_ready = 1'b0;
        end
    endtask

    task automatic push_read_byte(input string name, input logic [15:0] data);
        @(negedge clk);
        check_value({name, " ready"}, 16'd1, {15'd0, rd_ready});
        rd_data = data[7:0];
        rd_last = data[9];
        rd_valid = 1'b1;
        @(negedge clk);
        rd_valid = 1'b0;
    endtask

    // Bits 2..0 are levels, bit 3 a one-cycle missed ACK
    task automatic set_levels(input logic [15:0] data);
        @(negedge clk);
        busy = data[0];
        bus_control = data[1];
        bus_active = data[2];
        missed_ack = data[3];
        @(negedge clk);
        missed_ack = 1'b0;
    endtask

    task automatic run_row(input int r);
        logic [15:0] got;
        case (row_kind[r])
            K_WRITE: wb_access(row_name[r], 1'b1, row_addr[r], row_sel[r], row_data[r], got);
            K_READ: begin
                wb_access(row_name[r], 1'b0, row_addr[r], row_sel[r], 16'd0, got);
                if (row_addr[r] == ADDR_DATA && !row_exp[r][8]) begin
                    check_value(row_name[r], 16'd0, {15'd0, got[8]});
                end else begin
                    check_value(row_name[r], row_exp[r], got);
                end
                if (row_addr[r] == ADDR_PRESCALE) begin
                    check_value({row_name[r], " pin"}, row_exp[r], prescale);
                end
            end
            K_PUSH:  push_read_byte(row_name[r], row_data[r]);
            K_DRAIN: drain_stream(row_name[r], row_addr[r][0], row_exp[r]);
            default: set_levels(row_data[r]);
        endcase
    endtask

    task automatic build_table();
        logic [7:0]  b;
        logic [15:0] pend[$];
        // Prescale lanes
        add_row("prescale reset", K_READ, ADDR_PRESCALE, 2'b11, 0, 16'd250);
        add_row("prescale lo wr", K_WRITE, ADDR_PRESCALE, 2'b01, 16'h1234, 0);
        add_row("prescale lo rd", K_READ, ADDR_PRESCALE, 2'b11, 0, 16'h0034);
        add_row("prescale hi wr", K_WRITE, ADDR_PRESCALE, 2'b10, 16'hAB99, 0);
        add_row("prescale hi rd", K_READ, ADDR_PRESCALE, 2'b11, 0, 16'hAB34);
        // Commands
        add_row("cmd write", K_WRITE, ADDR_COMMAND, 2'b11, cmd_reg_word(7'h50, 5'b10100), 0);
        add_row("cmd readback", K_READ, ADDR_COMMAND, 2'b11, 0, cmd_reg_word(7'h50, 5'b10100));
        add_row("cmd out", K_DRAIN, 3'd0, 0, 0, {3'b0, 1'b1, 7'h50, 5'b10100});
        add_row("cmd no flags", K_WRITE, ADDR_COMMAND, 2'b11, cmd_reg_word(7'h21, 5'b0), 0);
        add_row("cmd none queued", K_DRAIN, 3'd0, 0, 0, 0);
        add_row("cmd q0", K_WRITE, ADDR_COMMAND, 2'b11, cmd_reg_word(7'h11, 5'b11000), 0);
        add_row("cmd q1", K_WRITE, ADDR_COMMAND, 2'b11, cmd_reg_word(7'h22, 5'b00110), 0);
        add_row("cmd q2", K_WRITE, ADDR_COMMAND, 2'b11, cmd_reg_word(7'h33, 5'b00001), 0);
        add_row("cmd out q0", K_DRAIN, 3'd0, 0, 0, {3'b0, 1'b1, 7'h11, 5'b11000});
        add_row("cmd out q1", K_DRAIN, 3'd0, 0, 0, {3'b0, 1'b1, 7'h22, 5'b00110});
        add_row("cmd out q2", K_DRAIN, 3'd0, 0, 0, {3'b0, 1'b1, 7'h33, 5'b00001});
        // Write data, last only on wide writes
        for (int i = 0; i < 5; i++) begin
            b = lfsr_byte();
            if (i < 4) begin
                add_row($sformatf("wide data %0d", i), K_WRITE, ADDR_DATA, 2'b11,
                        {6'b0, i == 3, 1'b0, b}, 0);
                pend.push_back({6'b0, 1'b1, b, i == 3});
            end else begin
                add_row("narrow data", K_WRITE, ADDR_DATA, 2'b01, {6'b0, 2'b10, b}, 0);
                pend.push_back({6'b0, 1'b1, b, 1'b0});
            end
        end
        foreach (pend[i]) begin
            add_row($sformatf("wr out %0d", i), K_DRAIN, 3'd1, 0, 0, pend[i]);
        end
        pend.delete();
        // Read data from the engine
        for (int i = 0; i < 3; i++) begin
            b = lfsr_byte();
            add_row($sformatf("engine byte %0d", i), K_PUSH, 0, 0, {6'b0, i == 2, 1'b0, b}, 0);
            pend.push_back({6'b0, i == 2, 1'b1, b});
        end
        foreach (pend[i]) begin
            add_row($sformatf("data read %0d", i), K_READ, ADDR_DATA, 2'b11, 0, pend[i]);
        end
        pend.delete();
        add_row("data read empty", K_READ, ADDR_DATA, 2'b11, 0, 0);
        // Command queue overflow
        for (int i = 0; i < 33; i++) begin
            add_row($sformatf("cmd fill %0d", i), K_WRITE, ADDR_COMMAND, 2'b11,
                    cmd_reg_word(7'(i), 5'b00100), 0);
        end
        add_row("cmd ovf set", K_READ, ADDR_STATUS, 2'b11, 0, S_CMD_F | S_CMD_OVF | S_WR_E | S_RD_E);
        add_row("cmd ovf clear", K_READ, ADDR_STATUS, 2'b11, 0, S_CMD_F | S_WR_E | S_RD_E);
        for (int i = 0; i < 32; i++) begin
            add_row($sformatf("cmd drain %0d", i), K_DRAIN, 3'd0, 0, 0,
                    {3'b0, 1'b1, 7'(i), 5'b00100});
        end
        add_row("cmd drained", K_DRAIN, 3'd0, 0, 0, 0);
        // Write queue overflow
        for (int i = 0; i < 33; i++) begin
            add_row($sformatf("wr fill %0d", i), K_WRITE, ADDR_DATA, 2'b01, 16'h0040 + i, 0);
        end
        add_row("wr ovf set", K_READ, ADDR_STATUS, 2'b11, 0, S_WR_F | S_WR_OVF | S_CMD_E | S_RD_E);
        add_row("wr ovf clear", K_READ, ADDR_STATUS, 2'b11, 0, S_WR_F | S_CMD_E | S_RD_E);
        for (int i = 0; i < 32; i++) begin
            add_row($sformatf("wr drain %0d", i), K_DRAIN, 3'd1, 0, 0,
                    {6'b0, 1'b1, 8'h40 + 8'(i), 1'b0});
        end
        add_row("wr drained", K_DRAIN, 3'd1, 0, 0, 0);
        // Engine status levels and missed ACK
        add_row("levels on", K_LEVEL, 0, 0, 16'h0007, 0);
        add_row("levels read", K_READ, ADDR_STATUS, 2'b11, 0, S_IDLE | 16'h0007);
        add_row("missed ack", K_LEVEL, 0, 0, 16'h0008, 0);
        add_row("miss hi read", K_READ, ADDR_STATUS, 2'b10, 0, S_IDLE | 16'h0008);
        add_row("miss lo read", K_READ, ADDR_STATUS, 2'b01, 0, S_IDLE | 16'h0008);
        add_row("miss cleared", K_READ, ADDR_STATUS, 2'b01, 0, S_IDLE);
    endtask

    initial begin
        rst = 1'b1;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_we = 1'b0;
        wb_sel = '0;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        cmd_ready = 1'b0;
        wr_ready = 1'b0;
        rd_data = '0;
        rd_last = 1'b0;
        rd_valid = 1'b0;
        busy = 1'b0;
        bus_control = 1'b0;
        bus_active = 1'b0;
        missed_ack = 1'b0;
        rows_ready = 1'b0;
        lfsr_state = 16'd43911;
        build_table();
        rows_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        wait (rows_ready === 1'b1);
        limit = row_name.size() * CYCLES_PER_ROW + 16;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Run timed out after %0d cycles", limit));
    end

endmodule

//--- dv/tb_clock_gen.sv
// ====================
// Testbench clock
// Free-running 8 ns clock
// ====================
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
    end

    // Half period of 4 ns
    always #4 clk_o = ~clk_o;

endmodule

//--- hw/byte_stream_fifo.sv
// ====================
// First-word-fall-through FIFO
// Head shown at the output, writes when full are dropped
// ====================
`timescale 1ns/1ps

module byte_stream_fifo #(
    parameter int WIDTH  = 8,
    parameter int ADDR_W = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output logic             full_o,
    output logic             empty_o
);
    localparam int DEPTH = 2 ** ADDR_W;

    logic [WIDTH-1:0] mem [DEPTH];
    // Extra top bit tells full from empty
    logic [ADDR_W:0]  wr_ptr;
    logic [ADDR_W:0]  rd_ptr;
    logic             push;
    logic             pop;

    assign empty_o = wr_ptr == rd_ptr;
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign push = in_valid_i & ~full_o;
    assign pop  = out_ready_i & ~empty_o;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_data_i;
        end
    end

    // Pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign in_ready_o  = ~full_o;
    assign out_valid_o = ~empty_o;
    assign out_data_o  = mem[rd_ptr[ADDR_W-1:0]];

endmodule

//--- hw/host_reg_file.sv
// ====================
// Host register file
// Command and prescale registers, queue pushes, sticky flags
// ====================
`timescale 1ns/1ps

module host_reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  i2c_host_pkg::host_word_t wbs_dat_i,
    input  logic                    wr_cmd_lo_i,
    input  logic                    wr_cmd_hi_i,
    input  logic                    wr_data_i,
    input  logic                    data_wide_i,
    input  logic                    wr_pre_lo_i,
    input  logic                    wr_pre_hi_i,
    input  logic                    rd_status_lo_i,
    input  logic                    rd_status_hi_i,
    input  logic                    missed_ack_i,
    input  logic                    cmd_full_i,
    input  logic                    wr_full_i,
    output i2c_host_pkg::cmd_word_t  cmd_word_o,
    output logic                    cmd_push_o,
    output i2c_host_pkg::i2c_byte_t  wr_byte_o,
    output logic                    wr_last_o,
    output logic                    wr_push_o,
    output i2c_host_pkg::prescale_t  prescale_o,
    output logic                    miss_ack_o,
    output logic                    cmd_ovf_o,
    output logic                    wr_ovf_o
);
    import i2c_host_pkg::*;

    cmd_word_t cmd_q;
    cmd_word_t cmd_next;
    prescale_t prescale_q;
    logic      miss_ack_q;
    logic      cmd_ovf_q;
    logic      wr_ovf_q;

    // Merge lane writes into the held command
    always_comb begin
        cmd_next = cmd_q;
        if (wr_cmd_lo_i) begin
            cmd_next[CMD_FLAGS_W +: $bits(i2c_addr_t)] = wbs_dat_i[CMD_ADDR_MSB:0];
        end
        if (wr_cmd_hi_i) begin
            // Flags are packed start first, stop last
            cmd_next[CMD_FLAGS_W-1:0] = {wbs_dat_i[CMD_START],
                                         wbs_dat_i[CMD_READ],
                                         wbs_dat_i[CMD_WRITE],
                                         wbs_dat_i[CMD_WR_MULT],
                                         wbs_dat_i[CMD_STOP]};
        end
    end

    // A high-lane write with any flag set queues the command
    assign cmd_word_o = cmd_next;
    assign cmd_push_o = wr_cmd_hi_i & (|cmd_next[CMD_FLAGS_W-1:0]);

    // Every data write queues one byte
    assign wr_byte_o = wbs_dat_i[DATA_MSB:0];
    assign wr_last_o = data_wide_i & wbs_dat_i[DATA_LAST];
    assign wr_push_o = wr_data_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q      <= '0;
            prescale_q <= DEFAULT_PRESCALE;
        end else begin
            cmd_q <= cmd_next;
            // Byte lanes of prescale
            if (wr_pre_lo_i) begin
                prescale_q[7:0] <= wbs_dat_i[7:0];
            end
            if (wr_pre_hi_i) begin
                prescale_q[15:8] <= wbs_dat_i[15:8];
            end
        end
    end

    // Sticky flags
    // A pulse in the clearing cycle still wins
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_ack_q <= 1'b0;
            cmd_ovf_q  <= 1'b0;
            wr_ovf_q   <= 1'b0;
        end else begin
            miss_ack_q <= (miss_ack_q & ~rd_status_lo_i) | missed_ack_i;
            // Full queue drops the push, flag it
            cmd_ovf_q  <= (cmd_ovf_q & ~rd_status_hi_i) | (cmd_push_o & cmd_full_i);
            wr_ovf_q   <= (wr_ovf_q & ~rd_status_hi_i) | (wr_push_o & wr_full_i);
        end
    end

    assign prescale_o = prescale_q;
    assign miss_ack_o = miss_ack_q;
    assign cmd_ovf_o  = cmd_ovf_q;
    assign wr_ovf_o   = wr_ovf_q;

endmodule

//--- hw/i2c_host_pkg.sv
// ====================
// I2C host register package
// Widths, register map, field positions and queue depths
// ====================
package i2c_host_pkg;

    // Wishbone side
    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] host_word_t;
    typedef logic [1:0]  byte_sel_t;

    // Engine side
    typedef logic [6:0]  i2c_addr_t;
    typedef logic [7:0]  i2c_byte_t;
    // Address, start, read, write, write_multiple, stop
    typedef logic [11:0] cmd_word_t;
    typedef logic [15:0] prescale_t;

    // Flag bits sit below the address in a command word
    localparam int CMD_FLAGS_W = 5;
    // Byte plus last flag
    localparam int DATA_ENTRY_W = 9;

    // Register map
    localparam reg_addr_t ADDR_STATUS   = 3'd0;
    localparam reg_addr_t ADDR_COMMAND  = 3'd2;
    localparam reg_addr_t ADDR_DATA     = 3'd4;
    localparam reg_addr_t ADDR_PRESCALE = 3'd6;

    localparam prescale_t DEFAULT_PRESCALE = 16'd250;

    // Queue depths as log2, 32 entries each
    localparam int CMD_FIFO_AW = 5;
    localparam int WR_FIFO_AW  = 5;
    localparam int RD_FIFO_AW  = 5;

    // Status register
    localparam int ST_BUSY      = 0;
    localparam int ST_BUS_CONT  = 1;
    localparam int ST_BUS_ACT   = 2;
    localparam int ST_MISS_ACK  = 3;
    localparam int ST_CMD_EMPTY = 8;
    localparam int ST_CMD_FULL  = 9;
    localparam int ST_CMD_OVF   = 10;
    localparam int ST_WR_EMPTY  = 11;
    localparam int ST_WR_FULL   = 12;
    localparam int ST_WR_OVF    = 13;
    localparam int ST_RD_EMPTY  = 14;
    localparam int ST_RD_FULL   = 15;

    // Command register
    localparam int CMD_ADDR_MSB = 6;
    localparam int CMD_START    = 8;
    localparam int CMD_READ     = 9;
    localparam int CMD_WRITE    = 10;
    localparam int CMD_WR_MULT  = 11;
    localparam int CMD_STOP     = 12;

    // Data register
    localparam int DATA_MSB   = 7;
    localparam int DATA_VALID = 8;
    localparam int DATA_LAST  = 9;

endpackage

//--- hw/i2c_host_regs_top.sv
// ====================
// I2C host register block
// Wishbone slave with command, write and read queues
// ====================
`timescale 1ns/1ps

module i2c_host_regs_top (
    input  logic                    clk,
    input  logic                    rst,
    // Wishbone slave
    input  i2c_host_pkg::reg_addr_t  wbs_adr_i,
    input  i2c_host_pkg::host_word_t wbs_dat_i,
    output i2c_host_pkg::host_word_t wbs_dat_o,
    input  logic                    wbs_we_i,
    input  i2c_host_pkg::byte_sel_t  wbs_sel_i,
    input  logic                    wbs_stb_i,
    output logic                    wbs_ack_o,
    input  logic                    wbs_cyc_i,
    // Command stream to engine
    output i2c_host_pkg::cmd_word_t  cmd_o,
    output logic                    cmd_valid_o,
    input  logic                    cmd_ready_i,
    // Write data stream to engine
    output i2c_host_pkg::i2c_byte_t  wr_data_o,
    output logic                    wr_last_o,
    output logic                    wr_valid_o,
    input  logic                    wr_ready_i,
    // Read data stream from engine
    input  i2c_host_pkg::i2c_byte_t  rd_data_i,
    input  logic                    rd_last_i,
    input  logic                    rd_valid_i,
    output logic                    rd_ready_o,
    // Engine status and config
    input  logic                    busy_i,
    input  logic                    bus_control_i,
    input  logic                    bus_active_i,
    input  logic                    missed_ack_i,
    output i2c_host_pkg::prescale_t  prescale_o
);
    import i2c_host_pkg::*;

    // Decode strobes
    logic acc, wr_cmd_lo, wr_cmd_hi, wr_data, data_wide;
    logic wr_pre_lo, wr_pre_hi, rd_status_lo, rd_status_hi, rd_data_pop;

    // Queue fills and flags
    cmd_word_t                cmd_word;
    i2c_byte_t                wr_byte;
    logic                     cmd_push, wr_push, wr_last;
    logic                     miss_ack, cmd_ovf, wr_ovf;
    logic                     cmd_full, cmd_empty, wr_full, wr_empty, rd_full, rd_empty;
    logic [DATA_ENTRY_W-1:0]  wr_head, rd_head;
    logic                     rd_head_valid, rd_pop;

    wb_access_decode u_decode (
        .clk, .rst, .wbs_adr_i, .wbs_we_i, .wbs_sel_i, .wbs_stb_i, .wbs_cyc_i, .wbs_ack_o,
        .acc_o(acc), .wr_cmd_lo_o(wr_cmd_lo), .wr_cmd_hi_o(wr_cmd_hi),
        .wr_data_o(wr_data), .data_wide_o(data_wide),
        .wr_pre_lo_o(wr_pre_lo), .wr_pre_hi_o(wr_pre_hi),
        .rd_status_lo_o(rd_status_lo), .rd_status_hi_o(rd_status_hi),
        .rd_data_pop_o(rd_data_pop)
    );

    host_reg_file u_regs (
        .clk, .rst, .wbs_dat_i,
        .wr_cmd_lo_i(wr_cmd_lo), .wr_cmd_hi_i(wr_cmd_hi), .wr_data_i(wr_data),
        .data_wide_i(data_wide), .wr_pre_lo_i(wr_pre_lo), .wr_pre_hi_i(wr_pre_hi),
        .rd_status_lo_i(rd_status_lo), .rd_status_hi_i(rd_status_hi),
        .missed_ack_i, .cmd_full_i(cmd_full), .wr_full_i(wr_full),
        .cmd_word_o(cmd_word), .cmd_push_o(cmd_push),
        .wr_byte_o(wr_byte), .wr_last_o(wr_last), .wr_push_o(wr_push),
        .prescale_o, .miss_ack_o(miss_ack), .cmd_ovf_o(cmd_ovf), .wr_ovf_o(wr_ovf)
    );

    byte_stream_fifo #(.WIDTH($bits(cmd_word_t)), .ADDR_W(CMD_FIFO_AW)) cmd_fifo (
        .clk, .rst, .in_data_i(cmd_word), .in_valid_i(cmd_push), .in_ready_o(),
        .out_data_o(cmd_o), .out_valid_o(cmd_valid_o), .out_ready_i(cmd_ready_i),
        .full_o(cmd_full), .empty_o(cmd_empty)
    );

    byte_stream_fifo #(.WIDTH(DATA_ENTRY_W), .ADDR_W(WR_FIFO_AW)) wr_fifo (
        .clk, .rst, .in_data_i({wr_byte, wr_last}), .in_valid_i(wr_push), .in_ready_o(),
        .out_data_o(wr_head), .out_valid_o(wr_valid_o), .out_ready_i(wr_ready_i),
        .full_o(wr_full), .empty_o(wr_empty)
    );

    // Byte over last flag
    assign wr_data_o = wr_head[DATA_ENTRY_W-1:1];
    assign wr_last_o = wr_head[0];

    byte_stream_fifo #(.WIDTH(DATA_ENTRY_W), .ADDR_W(RD_FIFO_AW)) rd_fifo (
        .clk, .rst, .in_data_i({rd_data_i, rd_last_i}), .in_valid_i(rd_valid_i),
        .in_ready_o(rd_ready_o), .out_data_o(rd_head), .out_valid_o(rd_head_valid),
        .out_ready_i(rd_pop), .full_o(rd_full), .empty_o(rd_empty)
    );

    reg_readback u_readback (
        .clk, .rst, .acc_i(acc), .wbs_adr_i, .rd_data_pop_i(rd_data_pop),
        .busy_i, .bus_control_i, .bus_active_i,
        .miss_ack_i(miss_ack), .cmd_ovf_i(cmd_ovf), .wr_ovf_i(wr_ovf),
        .cmd_empty_i(cmd_empty), .cmd_full_i(cmd_full),
        .wr_empty_i(wr_empty), .wr_full_i(wr_full),
        .rd_empty_i(rd_empty), .rd_full_i(rd_full),
        .cmd_word_i(cmd_word), .prescale_i(prescale_o),
        .rd_head_i(rd_head), .rd_head_valid_i(rd_head_valid),
        .wbs_dat_o, .rd_pop_o(rd_pop)
    );

endmodule

//--- hw/reg_readback.sv
// ====================
// Register readback
// Read data word per access, read queue pop
// ====================
`timescale 1ns/1ps

module reg_readback (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     acc_i,
    input  i2c_host_pkg::reg_addr_t                  wbs_adr_i,
    input  logic                                     rd_data_pop_i,
    input  logic                                     busy_i,
    input  logic                                     bus_control_i,
    input  logic                                     bus_active_i,
    input  logic                                     miss_ack_i,
    input  logic                                     cmd_ovf_i,
    input  logic                                     wr_ovf_i,
    input  logic                                     cmd_empty_i,
    input  logic                                     cmd_full_i,
    input  logic                                     wr_empty_i,
    input  logic                                     wr_full_i,
    input  logic                                     rd_empty_i,
    input  logic                                     rd_full_i,
    input  i2c_host_pkg::cmd_word_t                  cmd_word_i,
    input  i2c_host_pkg::prescale_t                  prescale_i,
    input  logic [i2c_host_pkg::DATA_ENTRY_W-1:0]    rd_head_i,
    input  logic                                     rd_head_valid_i,
    output i2c_host_pkg::host_word_t                 wbs_dat_o,
    output logic                                     rd_pop_o
);
    import i2c_host_pkg::*;

    host_word_t rd_word;
    host_word_t dat_q;

    // Word for the addressed register with unused bits zero
    always_comb begin
        rd_word = '0;
        case (wbs_adr_i)
            ADDR_STATUS: begin
                rd_word[ST_BUSY]      = busy_i;
                rd_word[ST_BUS_CONT]  = bus_control_i;
                rd_word[ST_BUS_ACT]   = bus_active_i;
                rd_word[ST_MISS_ACK]  = miss_ack_i;
                rd_word[ST_CMD_EMPTY] = cmd_empty_i;
                rd_word[ST_CMD_FULL]  = cmd_full_i;
                rd_word[ST_CMD_OVF]   = cmd_ovf_i;
                rd_word[ST_WR_EMPTY]  = wr_empty_i;
                rd_word[ST_WR_FULL]   = wr_full_i;
                rd_word[ST_WR_OVF]    = wr_ovf_i;
                rd_word[ST_RD_EMPTY]  = rd_empty_i;
                rd_word[ST_RD_FULL]   = rd_full_i;
            end
            ADDR_COMMAND: begin
                // Unpack address and flags back to register layout
                rd_word[CMD_ADDR_MSB:0] = cmd_word_i[CMD_FLAGS_W +: $bits(i2c_addr_t)];
                rd_word[CMD_START]      = cmd_word_i[4];
                rd_word[CMD_READ]       = cmd_word_i[3];
                rd_word[CMD_WRITE]      = cmd_word_i[2];
                rd_word[CMD_WR_MULT]    = cmd_word_i[1];
                rd_word[CMD_STOP]       = cmd_word_i[0];
            end
            ADDR_DATA: begin
                // Queue head with the byte above the last flag
                rd_word[DATA_MSB:0] = rd_head_i[DATA_ENTRY_W-1:1];
                rd_word[DATA_VALID] = rd_head_valid_i;
                rd_word[DATA_LAST]  = rd_head_i[0];
            end
            ADDR_PRESCALE: rd_word = prescale_i;
            default: rd_word = '0;
        endcase
    end

    // Loaded at accept and valid alongside ack
    always_ff @(posedge clk) begin
        if (rst) begin
            dat_q <= '0;
        end else if (acc_i) begin
            dat_q <= rd_word;
        end
    end

    assign wbs_dat_o = dat_q;
    // Pop only a real entry
    assign rd_pop_o = rd_data_pop_i & rd_head_valid_i;

endmodule

//--- hw/wb_access_decode.sv
// ====================
// Wishbone access decode
// One ack per access, single-cycle register strobes
// ====================
`timescale 1ns/1ps

module wb_access_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  i2c_host_pkg::reg_addr_t wbs_adr_i,
    input  logic                   wbs_we_i,
    input  i2c_host_pkg::byte_sel_t wbs_sel_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    output logic                   wbs_ack_o,
    output logic                   acc_o,
    output logic                   wr_cmd_lo_o,
    output logic                   wr_cmd_hi_o,
    output logic                   wr_data_o,
    output logic                   data_wide_o,
    output logic                   wr_pre_lo_o,
    output logic                   wr_pre_hi_o,
    output logic                   rd_status_lo_o,
    output logic                   rd_status_hi_o,
    output logic                   rd_data_pop_o
);
    import i2c_host_pkg::*;

    logic ack_q;
    logic acc_wr;
    logic acc_rd;

    // New access only while ack is low
    assign acc_o  = wbs_cyc_i & wbs_stb_i & ~ack_q;
    assign acc_wr = acc_o & wbs_we_i;
    assign acc_rd = acc_o & ~wbs_we_i;

    // Ack in the cycle after accept, always one cycle wide
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc_o;
        end
    end

    assign wbs_ack_o = ack_q;

    // Write strobes
    assign wr_cmd_lo_o = acc_wr && wbs_adr_i == ADDR_COMMAND && wbs_sel_i[0];
    assign wr_cmd_hi_o = acc_wr && wbs_adr_i == ADDR_COMMAND && wbs_sel_i[1];
    assign wr_pre_lo_o = acc_wr && wbs_adr_i == ADDR_PRESCALE && wbs_sel_i[0];
    assign wr_pre_hi_o = acc_wr && wbs_adr_i == ADDR_PRESCALE && wbs_sel_i[1];
    // Data byte needs the low lane
    assign wr_data_o   = acc_wr && wbs_adr_i == ADDR_DATA && wbs_sel_i[0];
    // Last bit only counts on a full 16-bit write
    assign data_wide_o = wr_data_o & wbs_sel_i[1];

    // Read side effects
    assign rd_status_lo_o = acc_rd && wbs_adr_i == ADDR_STATUS && wbs_sel_i[0];
    assign rd_status_hi_o = acc_rd && wbs_adr_i == ADDR_STATUS && wbs_sel_i[1];
    assign rd_data_pop_o  = acc_rd && wbs_adr_i == ADDR_DATA && wbs_sel_i[0];

endmodule

//--- i2c_host_regs_top.f
hw/i2c_host_pkg.sv
hw/byte_stream_fifo.sv
hw/wb_access_decode.sv
hw/host_reg_file.sv
hw/reg_readback.sv
hw/i2c_host_regs_top.sv
dv/tb_clock_gen.sv
dv/i2c_host_regs_props.sv
dv/i2c_host_regs_tb.sv
